/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

  // ====================================================================
  // Widths
  // ====================================================================
  typedef logic [31:0] data_t;
  typedef logic [4:0]  reg_id_t;

  // Operations reaching the back end, already decoded
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_MUL = 3'd6
  } op_t;

  // ====================================================================
  // Default sizes
  // ====================================================================
  parameter int DEFAULT_ROB_DEPTH  = 8;
  parameter int DEFAULT_MUL_STAGES = 5;

  // Tag into the reorder buffer
  typedef logic [$clog2(DEFAULT_ROB_DEPTH)-1:0] rob_idx_t;

endpackage

`default_nettype wire

/* alu_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_lane import exec_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     issue_i,
  input  op_t      op_i,
  input  data_t    a_i,
  input  data_t    b_i,
  input  rob_idx_t idx_i,
  input  reg_id_t  rd_i,
  input  logic     grant_i,
  output logic     done_o,
  output logic     busy_o,
  output rob_idx_t idx_o,
  output reg_id_t  rd_o,
  output data_t    result_o
);

  logic     valid_q;
  data_t    result_q;
  rob_idx_t idx_q;
  reg_id_t  rd_q;
  data_t    alu_res;

  always_comb begin : alu_op
    case (op_i)
      OP_ADD:  alu_res = a_i + b_i;
      OP_SUB:  alu_res = a_i - b_i;
      OP_AND:  alu_res = a_i & b_i;
      OP_OR:   alu_res = a_i | b_i;
      OP_XOR:  alu_res = a_i ^ b_i;
      OP_SLL:  alu_res = a_i << b_i[4:0];
      default: alu_res = '0;
    endcase
  end

  // Entry stays valid until writeback takes it
  always_ff @(posedge clk_i) begin : entry_valid
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else if (issue_i) begin
      valid_q <= 1'b1;
    end else if (grant_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin : entry_payload
    if (issue_i) begin
      result_q <= alu_res;
      idx_q    <= idx_i;
      rd_q     <= rd_i;
    end
  end

  assign done_o   = valid_q;
  assign busy_o   = valid_q && !grant_i;
  assign idx_o    = idx_q;
  assign rd_o     = rd_q;
  assign result_o = result_q;

  // A result that lost arbitration waits untouched
  held_result_stable : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    (valid_q && !grant_i) |=> (valid_q && $stable(result_q) && $stable(idx_q))
  ) else $error("ALU result changed while waiting for writeback");

endmodule

`default_nettype wire

/* mul_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_lane import exec_pkg::*; #(
  parameter int MUL_STAGES = DEFAULT_MUL_STAGES
)(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     issue_i,
  input  data_t    a_i,
  input  data_t    b_i,
  input  rob_idx_t idx_i,
  input  reg_id_t  rd_i,
  output logic     done_o,
  output rob_idx_t idx_o,
  output reg_id_t  rd_o,
  output data_t    result_o
);

  logic [MUL_STAGES-1:0] valid_q;
  rob_idx_t idx_q [MUL_STAGES];
  reg_id_t  rd_q  [MUL_STAGES];

  // Stage 0 partial products, low 32 bits are all that matter
  data_t pp_lo_q;
  data_t pp_hi_q;
  data_t prod_q [1:MUL_STAGES-1];

  always_ff @(posedge clk_i) begin : stage_valid
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[MUL_STAGES-2:0], issue_i};
    end
  end

  // ====================================================================
  // Datapath, never stalls
  // ====================================================================
  always_ff @(posedge clk_i) begin : stage_data
    pp_lo_q  <= a_i[15:0] * b_i;
    pp_hi_q  <= a_i[31:16] * b_i;
    idx_q[0] <= idx_i;
    rd_q[0]  <= rd_i;

    prod_q[1] <= pp_lo_q + (pp_hi_q << 16);

    for (int i = 1; i < MUL_STAGES; i++) begin
      idx_q[i] <= idx_q[i-1];
      rd_q[i]  <= rd_q[i-1];
    end

    // Remaining stages only delay the product
    for (int i = 2; i < MUL_STAGES; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign done_o   = valid_q[MUL_STAGES-1];
  assign idx_o    = idx_q[MUL_STAGES-1];
  assign rd_o     = rd_q[MUL_STAGES-1];
  assign result_o = prod_q[MUL_STAGES-1];

endmodule

`default_nettype wire

/* wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter import exec_pkg::*; (
  input  logic     alu_done_i,
  input  rob_idx_t alu_idx_i,
  input  reg_id_t  alu_rd_i,
  input  data_t    alu_result_i,
  input  logic     mul_done_i,
  input  rob_idx_t mul_idx_i,
  input  reg_id_t  mul_rd_i,
  input  data_t    mul_result_i,
  output logic     wb_valid_o,
  output rob_idx_t wb_idx_o,
  output reg_id_t  wb_rd_o,
  output data_t    wb_data_o,
  output logic     alu_grant_o
);

  // Multiply lane cannot stall, so it always wins
  always_comb begin : select
    if (mul_done_i) begin
      wb_idx_o  = mul_idx_i;
      wb_rd_o   = mul_rd_i;
      wb_data_o = mul_result_i;
    end else begin
      wb_idx_o  = alu_idx_i;
      wb_rd_o   = alu_rd_i;
      wb_data_o = alu_result_i;
    end
  end

  assign wb_valid_o  = mul_done_i || alu_done_i;
  assign alu_grant_o = alu_done_i && !mul_done_i;

  // Both pending results belong to live, distinct reorder-buffer entries
  always_comb begin : grant_check
    distinct_tags : assert final (!(alu_done_i && mul_done_i && (alu_idx_i == mul_idx_i)))
      else $error("ALU and multiply results carry the same tag");
  end

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import exec_pkg::*; #(
  parameter int ROB_DEPTH = DEFAULT_ROB_DEPTH
)(
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     alloc_i,
  input  logic     wb_valid_i,
  input  rob_idx_t wb_idx_i,
  input  reg_id_t  wb_rd_i,
  input  data_t    wb_data_i,
  output rob_idx_t alloc_idx_o,
  output logic     full_o,
  output logic     commit_valid_o,
  output reg_id_t  commit_rd_o,
  output data_t    commit_data_o
);

  rob_idx_t head_q;
  rob_idx_t tail_q;
  logic [$clog2(ROB_DEPTH):0] count_q;

  logic [ROB_DEPTH-1:0] complete_q;
  reg_id_t rd_q   [ROB_DEPTH];
  data_t   data_q [ROB_DEPTH];

  // ====================================================================
  // Commit and occupancy
  // ====================================================================
  assign commit_valid_o = (count_q != '0) && complete_q[head_q];
  assign commit_rd_o    = rd_q[head_q];
  assign commit_data_o  = data_q[head_q];
  assign alloc_idx_o    = tail_q;

  // Slot freed by a commit is reusable in the same cycle
  assign full_o = (count_q == ROB_DEPTH) && !commit_valid_o;

  always_ff @(posedge clk_i) begin : pointers
    if (!rst_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc_i) begin
        tail_q <= tail_q + 1'b1;
      end
      if (commit_valid_o) begin
        head_q <= head_q + 1'b1;
      end
      case ({alloc_i, commit_valid_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // New entries start incomplete, completions land out of order
  always_ff @(posedge clk_i) begin : complete_bits
    if (!rst_i) begin
      complete_q <= '0;
    end else begin
      if (alloc_i) begin
        complete_q[tail_q] <= 1'b0;
      end
      if (wb_valid_i) begin
        complete_q[wb_idx_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : entry_payload
    if (wb_valid_i) begin
      rd_q[wb_idx_i]   <= wb_rd_i;
      data_q[wb_idx_i] <= wb_data_i;
    end
  end

  // ====================================================================
  // Checks
  // ====================================================================
  no_alloc_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    alloc_i |-> !full_o
  ) else $error("Allocation while reorder buffer is full");

  // Tag must lie between head and tail
  wb_to_live_entry : assert property (
    @(posedge clk_i) disable iff (!rst_i)
    wb_valid_i |-> (rob_idx_t'(wb_idx_i - head_q) < count_q) && !complete_q[wb_idx_i]
  ) else $error("Completion for an entry that is not outstanding");

endmodule

`default_nettype wire

/* exec_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_backend import exec_pkg::*; #(
  parameter int ROB_DEPTH  = DEFAULT_ROB_DEPTH,
  parameter int MUL_STAGES = DEFAULT_MUL_STAGES
)(
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    issue_valid_i,
  input  op_t     issue_op_i,
  input  data_t   issue_a_i,
  input  data_t   issue_b_i,
  input  reg_id_t issue_rd_i,
  output logic    issue_ready_o,
  output logic    commit_valid_o,
  output reg_id_t commit_rd_o,
  output data_t   commit_data_o
);

  logic     is_mul;
  logic     accept;
  logic     rob_full;
  rob_idx_t alloc_idx;

  logic     alu_done, alu_busy, alu_grant;
  rob_idx_t alu_idx;
  reg_id_t  alu_rd;
  data_t    alu_result;

  logic     mul_done;
  rob_idx_t mul_idx;
  reg_id_t  mul_rd;
  data_t    mul_result;

  logic     wb_valid;
  rob_idx_t wb_idx;
  reg_id_t  wb_rd;
  data_t    wb_data;

  // Lane select and issue handshake
  assign is_mul        = (issue_op_i == OP_MUL);
  assign issue_ready_o = !rob_full && (is_mul || !alu_busy);
  assign accept        = issue_valid_i && issue_ready_o;

  alu_lane i_alu_lane (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .issue_i  (accept && !is_mul),
    .op_i     (issue_op_i),
    .a_i      (issue_a_i),
    .b_i      (issue_b_i),
    .idx_i    (alloc_idx),
    .rd_i     (issue_rd_i),
    .grant_i  (alu_grant),
    .done_o   (alu_done),
    .busy_o   (alu_busy),
    .idx_o    (alu_idx),
    .rd_o     (alu_rd),
    .result_o (alu_result)
  );

  mul_lane #(
    .MUL_STAGES (MUL_STAGES)
  ) i_mul_lane (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .issue_i  (accept && is_mul),
    .a_i      (issue_a_i),
    .b_i      (issue_b_i),
    .idx_i    (alloc_idx),
    .rd_i     (issue_rd_i),
    .done_o   (mul_done),
    .idx_o    (mul_idx),
    .rd_o     (mul_rd),
    .result_o (mul_result)
  );

  wb_arbiter i_wb_arbiter (
    .alu_done_i   (alu_done),
    .alu_idx_i    (alu_idx),
    .alu_rd_i     (alu_rd),
    .alu_result_i (alu_result),
    .mul_done_i   (mul_done),
    .mul_idx_i    (mul_idx),
    .mul_rd_i     (mul_rd),
    .mul_result_i (mul_result),
    .wb_valid_o   (wb_valid),
    .wb_idx_o     (wb_idx),
    .wb_rd_o      (wb_rd),
    .wb_data_o    (wb_data),
    .alu_grant_o  (alu_grant)
  );

  reorder_buffer #(
    .ROB_DEPTH (ROB_DEPTH)
  ) i_reorder_buffer (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .alloc_i        (accept),
    .wb_valid_i     (wb_valid),
    .wb_idx_i       (wb_idx),
    .wb_rd_i        (wb_rd),
    .wb_data_i      (wb_data),
    .alloc_idx_o    (alloc_idx),
    .full_o         (rob_full),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

endmodule

`default_nettype wire

/* tb_exec_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_backend import exec_pkg::*; ();

  localparam int ROB_DEPTH  = DEFAULT_ROB_DEPTH;
  localparam int MUL_STAGES = DEFAULT_MUL_STAGES;
  localparam int N_ALU      = 24;
  localparam int N_MUL      = 24;
  localparam int N_STREAM   = 40;
  localparam int N_MIX      = 80;
  localparam int N_GAP      = 60;
  localparam int TOTAL_OPS  = N_ALU + N_MUL + N_STREAM + N_MIX + N_GAP;
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * (MUL_STAGES + ROB_DEPTH) + 100;

  logic    clk_i;
  logic    rst_i;
  logic    issue_valid_i;
  op_t     issue_op_i;
  data_t   issue_a_i;
  data_t   issue_b_i;
  reg_id_t issue_rd_i;
  logic    issue_ready_o;
  logic    commit_valid_o;
  reg_id_t commit_rd_o;
  data_t   commit_data_o;

  integer  seed = 32'h9770;
  data_t   exp_data_q[$];
  reg_id_t exp_rd_q[$];
  int      accepted_cnt = 0;
  int      committed_cnt = 0;
  int      outstanding = 0;

  exec_backend i_exec_backend (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .issue_valid_i  (issue_valid_i),
    .issue_op_i     (issue_op_i),
    .issue_a_i      (issue_a_i),
    .issue_b_i      (issue_b_i),
    .issue_rd_i     (issue_rd_i),
    .issue_ready_o  (issue_ready_o),
    .commit_valid_o (commit_valid_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ====================================================================
  // Reference model and checks
  // ====================================================================
  function automatic data_t expected_result(input op_t op, input data_t a, input data_t b);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_MUL:  return prod[31:0];
      default: return '0;
    endcase
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "testbench stopped on error");
  endtask

  task automatic check_data(input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: commit data 0x%08h, expected 0x%08h", $time, got, exp));
    end
  endtask

  task automatic check_rd(input reg_id_t got, input reg_id_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t: commit register x%0d, expected x%0d", $time, got, exp));
    end
  endtask

  always @(posedge clk_i) begin : record_issue
    if (rst_i && issue_valid_i && issue_ready_o) begin
      exp_data_q.push_back(expected_result(issue_op_i, issue_a_i, issue_b_i));
      exp_rd_q.push_back(issue_rd_i);
      accepted_cnt++;
    end
  end

  always @(posedge clk_i) begin : compare_commit
    if (rst_i && commit_valid_o) begin
      if (exp_data_q.size() == 0) begin
        abort_run("A commit arrived with no operation outstanding");
      end else begin
        check_rd(commit_rd_o, exp_rd_q.pop_front());
        check_data(commit_data_o, exp_data_q.pop_front());
        committed_cnt++;
      end
    end
  end

  // Accepted but not yet committed
  always @(posedge clk_i) begin : occupancy
    if (rst_i) begin
      if (outstanding == ROB_DEPTH && !commit_valid_o && issue_ready_o) begin
        abort_run("issue_ready_o stayed high with the reorder buffer full");
      end
      if (issue_valid_i && issue_ready_o) begin
        outstanding = outstanding + 1;
      end
      if (commit_valid_o) begin
        outstanding = outstanding - 1;
      end
      if (outstanding > ROB_DEPTH) begin
        abort_run("More operations outstanding than the reorder buffer holds");
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: commits stopped arriving before every operation retired");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  // ====================================================================
  // Stimulus
  // ====================================================================
  task automatic send_op(input op_t op, input data_t a, input data_t b);
    issue_valid_i <= 1'b1;
    issue_op_i    <= op;
    issue_a_i     <= a;
    issue_b_i     <= b;
    issue_rd_i    <= reg_id_t'($random(seed));
    @(posedge clk_i);
    while (!issue_ready_o) @(posedge clk_i);
  endtask

  task automatic idle(input int cycles);
    issue_valid_i <= 1'b0;
    repeat (cycles) @(posedge clk_i);
  endtask

  initial begin : stimulus
    rst_i         <= 1'b0;
    issue_valid_i <= 1'b0;
    issue_op_i    <= OP_ADD;
    issue_a_i     <= '0;
    issue_b_i     <= '0;
    issue_rd_i    <= '0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b1;

    // Quiet back end right after reset
    repeat (3) begin
      @(posedge clk_i);
      if (commit_valid_o || !issue_ready_o) begin
        abort_run("Back end not idle and ready after reset");
      end
    end

    for (int i = 0; i < N_ALU; i++) begin
      send_op(op_t'($unsigned($random(seed)) % 6), $random(seed), $random(seed));
    end

    send_op(OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    for (int i = 1; i < N_MUL; i++) begin
      send_op(OP_MUL, $random(seed), $random(seed));
    end

    // Multiply stream with one ALU op that loses writeback
    for (int i = 0; i < N_STREAM; i++) begin
      if (i == 5) begin
        send_op(OP_XOR, $random(seed), $random(seed));
      end else begin
        send_op(OP_MUL, $random(seed), $random(seed));
      end
    end

    for (int i = 0; i < N_MIX; i++) begin
      send_op(op_t'($unsigned($random(seed)) % 7), $random(seed), $random(seed));
    end

    for (int i = 0; i < N_GAP; i++) begin
      idle($unsigned($random(seed)) % 3);
      send_op(op_t'($unsigned($random(seed)) % 7), $random(seed), $random(seed));
    end
    idle(0);

    while (exp_data_q.size() != 0) @(posedge clk_i);
    repeat (2 * MUL_STAGES) @(posedge clk_i);

    if (accepted_cnt == TOTAL_OPS && committed_cnt == TOTAL_OPS) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Accepted %0d and committed %0d operations, expected %0d of each",
               accepted_cnt, committed_cnt, TOTAL_OPS);
      $display("Result: FAILED");
      $fatal(1, "operation count mismatch");
    end
  end

endmodule

`default_nettype wire

/* sources.f */
exec_pkg.sv
alu_lane.sv
mul_lane.sv
wb_arbiter.sv
reorder_buffer.sv
exec_backend.sv
tb_exec_backend.sv
